// File: vid_params.svh
`ifndef VID_PARAMS_SVH
`define VID_PARAMS_SVH

`define VID_DATA_W      32
`define VID_CMD_W       3
`define VID_TIMING_W    13
`define VID_PCNT_W      6
`define VID_COLOR_W     8
`define VID_RGB_W       (3 * `VID_COLOR_W)
`define VID_FIFO_DEPTH  16

`define VID_CMD_IDLE    3'b000              // Nothing on the bus
`define VID_CMD_WR_ADDR 3'b100              // Address phase
`define VID_CMD_WR_DATA 3'b001              // Data phase
`define VID_CMD_PIXEL   3'b011              // Pixel push

`define VID_REG_CR      32'h0000_0000
`define VID_REG_H1      32'h0000_0028
`define VID_REG_H2      32'h0000_0030
`define VID_REG_V1      32'h0000_0038
`define VID_REG_V2      32'h0000_0040

`define VID_CR_EN_BIT   3                   // Enable in CR
`define VID_CR_PCNT_LSB 4                   // Divider in CR[9:4]

`endif

// File: vid_pkg.sv
`default_nettype none

`include "vid_params.svh"

package vid_pkg;

    typedef struct packed {
        logic [`VID_COLOR_W-1:0] red;
        logic [`VID_COLOR_W-1:0] green;
        logic [`VID_COLOR_W-1:0] blue;
    } vid_rgb_t;

    // Register write view of a bus word
    typedef struct packed {
        logic [`VID_DATA_W-2*`VID_TIMING_W-1:0] spare;
        logic [`VID_TIMING_W-1:0]               hi;     // Size or sync start
        logic [`VID_TIMING_W-1:0]               lo;     // End, sync end or the CR bits
    } vid_timing_word_t;

    // Pixel push view of a bus word
    typedef struct packed {
        logic [`VID_DATA_W-`VID_RGB_W-1:0] pad;
        vid_rgb_t                          rgb;
    } vid_pixel_word_t;

    typedef union packed {
        vid_timing_word_t timing;
        vid_pixel_word_t  pixel;
    } vid_bus_word_u;

    typedef struct packed {
        logic                     en;
        logic [`VID_PCNT_W-1:0]   pcnt;
        logic [`VID_TIMING_W-1:0] hsize;
        logic [`VID_TIMING_W-1:0] hend;
        logic [`VID_TIMING_W-1:0] hsync_start;
        logic [`VID_TIMING_W-1:0] hsync_end;
        logic [`VID_TIMING_W-1:0] vsize;
        logic [`VID_TIMING_W-1:0] vend;
        logic [`VID_TIMING_W-1:0] vsync_start;
        logic [`VID_TIMING_W-1:0] vsync_end;
    } vid_cfg_t;

    typedef struct packed {
        logic pixel_tick;
        logic hsync;
        logic hblank;
        logic vsync;
        logic vblank;
    } vid_timing_t;

endpackage

`default_nettype wire

// File: vid_bus_decode.sv
`default_nettype none

`include "vid_params.svh"

module vid_bus_decode (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic [`VID_CMD_W-1:0] cmd,
    input  wire vid_pkg::vid_bus_word_u addr_data,
    output vid_pkg::vid_cfg_t          cfg,
    output logic                       push,
    output vid_pkg::vid_rgb_t          push_pixel
);

    logic [`VID_DATA_W-1:0] offset;        // Latched register offset
    logic                   addr_pend;     // Address phase seen, data due
    logic                   data_beat;

    assign data_beat = (cmd == `VID_CMD_WR_DATA) && addr_pend;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            offset    <= '0;
            addr_pend <= 1'b0;
        end else if (cmd == `VID_CMD_WR_ADDR) begin
            offset    <= addr_data;
            addr_pend <= 1'b1;
        end else if (cmd == `VID_CMD_WR_DATA) begin
            addr_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg <= '0;
        end else if (data_beat) begin
            case (offset)
                `VID_REG_CR: begin
                    cfg.en   <= addr_data.timing.lo[`VID_CR_EN_BIT];
                    cfg.pcnt <= addr_data.timing.lo[`VID_CR_PCNT_LSB +: `VID_PCNT_W];
                end
                `VID_REG_H1: begin
                    cfg.hsize <= addr_data.timing.hi;
                    cfg.hend  <= addr_data.timing.lo;
                end
                `VID_REG_H2: begin
                    cfg.hsync_start <= addr_data.timing.hi;
                    cfg.hsync_end   <= addr_data.timing.lo;
                end
                `VID_REG_V1: begin
                    cfg.vsize <= addr_data.timing.hi;
                    cfg.vend  <= addr_data.timing.lo;
                end
                `VID_REG_V2: begin
                    cfg.vsync_start <= addr_data.timing.hi;
                    cfg.vsync_end   <= addr_data.timing.lo;
                end
                default: ;                      // Unknown offset dropped
            endcase
        end
    end

    assign push       = (cmd == `VID_CMD_PIXEL);
    assign push_pixel = addr_data.pixel.rgb;

    a_data_after_addr: assert property (@(posedge clk) disable iff (!reset_n)
        (cmd == `VID_CMD_WR_DATA) |-> addr_pend)
        else $error("data beat without a preceding address beat");

endmodule

`default_nettype wire

// File: vid_pixel_fifo.sv
`default_nettype none

`include "vid_params.svh"

module vid_pixel_fifo #(
    parameter int DEPTH = `VID_FIFO_DEPTH
) (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic                  push,
    input  wire logic [`VID_RGB_W-1:0] push_pixel,
    input  wire logic                  pop,
    output logic [`VID_RGB_W-1:0]      head,
    output logic                       empty,
    output logic                       full,
    output logic                       overflow
);

    localparam int AW = $clog2(DEPTH);

    logic [`VID_RGB_W-1:0] mem [DEPTH];
    logic [AW:0]           wr_ptr;          // Extra bit tells full from empty
    logic [AW:0]           rd_ptr;
    logic [AW:0]           fill;
    logic                  wr_en;
    logic                  rd_en;

    assign fill  = wr_ptr - rd_ptr;
    assign full  = (fill == (AW+1)'(DEPTH));
    assign empty = (fill == '0);
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;
    assign head  = mem[rd_ptr[AW-1:0]];     // Show-ahead read

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= push_pixel;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && full) begin
                overflow <= 1'b1;           // Sticky until reset
            end
        end
    end

    a_fill_bound: assert property (@(posedge clk) disable iff (!reset_n)
        fill <= (AW+1)'(DEPTH))
        else $error("FIFO fill count above depth");

endmodule

`default_nettype wire

// File: vid_timing_gen.sv
`default_nettype none

`include "vid_params.svh"

module vid_timing_gen (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire vid_pkg::vid_cfg_t cfg,
    output vid_pkg::vid_timing_t   timing
);

    logic [`VID_PCNT_W-1:0]   div_cnt;
    logic [`VID_TIMING_W-1:0] hcount;
    logic [`VID_TIMING_W-1:0] vcount;
    logic                     tick;
    logic                     line_end;
    logic                     frame_end;

    assign tick      = cfg.en && (div_cnt == cfg.pcnt);
    assign line_end  = (hcount == cfg.hend);
    assign frame_end = (vcount == cfg.vend);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            hcount  <= '0;
            vcount  <= '0;
        end else if (!cfg.en) begin
            div_cnt <= '0;                  // Held at zero while disabled
            hcount  <= '0;
            vcount  <= '0;
        end else if (tick) begin
            div_cnt <= '0;
            if (line_end) begin
                hcount <= '0;
                vcount <= frame_end ? '0 : vcount + 1'b1;
            end else begin
                hcount <= hcount + 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Sync and blank decoded straight from the registered counts
    always_comb begin
        timing.pixel_tick = tick;
        timing.hblank     = !cfg.en || (hcount >= cfg.hsize);
        timing.hsync      = cfg.en && (hcount >= cfg.hsync_start)
                                   && (hcount < cfg.hsync_end);
        timing.vblank     = !cfg.en || (vcount >= cfg.vsize);
        timing.vsync      = cfg.en && (vcount >= cfg.vsync_start)
                                   && (vcount < cfg.vsync_end);
    end

    a_hcount_range: assert property (@(posedge clk) disable iff (!reset_n)
        cfg.en |-> (hcount <= cfg.hend))
        else $error("horizontal count past hend");

endmodule

`default_nettype wire

// File: vid_pixel_out.sv
`default_nettype none

`include "vid_params.svh"

module vid_pixel_out (
    input  wire logic                 clk,
    input  wire logic                 reset_n,
    input  wire vid_pkg::vid_timing_t timing,
    input  wire vid_pkg::vid_rgb_t    head,
    input  wire logic                 empty,
    output logic                      pop,
    output vid_pkg::vid_rgb_t         rgb,
    output logic                      underflow
);

    logic active;                           // Inside both visible windows

    assign active = !timing.hblank && !timing.vblank;
    assign pop    = timing.pixel_tick && active && !empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rgb       <= '0;
            underflow <= 1'b0;
        end else begin
            if (!active) begin
                rgb <= '0;                  // Black during blanking
            end else if (timing.pixel_tick) begin
                rgb <= empty ? '0 : head;
            end
            if (timing.pixel_tick && active && empty) begin
                underflow <= 1'b1;          // Sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

// File: vid_controller.sv
`default_nettype none

`include "vid_params.svh"

module vid_controller (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic [`VID_CMD_W-1:0]  cmd,
    input  wire vid_pkg::vid_bus_word_u addr_data,
    output logic                        pixel_ready,
    output logic                        overflow,
    output logic                        underflow,
    output logic                        hsync,
    output logic                        hblank,
    output logic                        vsync,
    output logic                        vblank,
    output vid_pkg::vid_rgb_t           rgb
);

    import vid_pkg::*;

    vid_cfg_t    cfg;
    vid_timing_t timing;
    vid_rgb_t    push_pixel;
    vid_rgb_t    head;
    logic        push;
    logic        pop;
    logic        empty;
    logic        full;

    vid_bus_decode u_decode (
        .clk        (clk),
        .reset_n    (reset_n),
        .cmd        (cmd),
        .addr_data  (addr_data),
        .cfg        (cfg),
        .push       (push),
        .push_pixel (push_pixel)
    );

    vid_pixel_fifo #(
        .DEPTH (`VID_FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .reset_n    (reset_n),
        .push       (push),
        .push_pixel (push_pixel),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .full       (full),
        .overflow   (overflow)
    );

    vid_timing_gen u_timing (
        .clk     (clk),
        .reset_n (reset_n),
        .cfg     (cfg),
        .timing  (timing)
    );

    vid_pixel_out u_out (
        .clk       (clk),
        .reset_n   (reset_n),
        .timing    (timing),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .rgb       (rgb),
        .underflow (underflow)
    );

    assign pixel_ready = !full;             // Back-pressure to the bus driver
    assign hsync       = timing.hsync;
    assign hblank      = timing.hblank;
    assign vsync       = timing.vsync;
    assign vblank      = timing.vblank;

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;                     // Released just after an edge
    end

endmodule

`default_nettype wire

// File: tb_vid_controller.sv
`default_nettype none

`include "vid_params.svh"

module tb_vid_controller;

    import vid_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_TESTS       = 6;
    localparam int PIXELS          = `VID_FIFO_DEPTH;
    localparam int PCNT            = 1;
    localparam int HEND            = 7;
    localparam int VEND            = 3;
    localparam int LINE_CLKS       = (HEND + 1) * (PCNT + 1);
    localparam int FRAME_CLKS      = (VEND + 1) * LINE_CLKS;
    localparam int SETUP_CLKS      = RESET_CYCLES + 8 + 5 * 3 + (PIXELS + 1) * 2 + 10;
    localparam int WATCHDOG_CYCLES = SETUP_CLKS + 4 * FRAME_CLKS + 100;

    logic                  clk;
    logic                  reset_n;
    logic [`VID_CMD_W-1:0] cmd;
    vid_bus_word_u         addr_data;
    logic                  pixel_ready;
    logic                  overflow;
    logic                  underflow;
    logic                  hsync;
    logic                  hblank;
    logic                  vsync;
    logic                  vblank;
    vid_rgb_t              rgb;

    vid_rgb_t   ref_q [$];                  // Pixels the FIFO accepted
    vid_rgb_t   exp_pix = '0;
    vid_rgb_t   rgb_prev = '0;
    int         chk_idx = 0;                // Pixels seen on rgb so far
    int         seed = 64;
    int         fail_cnt [1:NUM_TESTS] = '{default: 0};
    int         cyc = 0;
    int         last_hrise = 0;
    int         last_vrise = 0;
    int         hrise_cnt = 0;
    int         vrise_cnt = 0;
    logic       hsync_prev = 1'b0;
    logic       vsync_prev = 1'b0;
    logic       blank_prev = 1'b1;
    logic       reset_chk = 1'b0;
    logic [1:0] ovf_stage = 2'd0;           // 1 after 16 pushes, 2 after the extra one
    logic       uf_chk = 1'b0;
    logic [6:0] status;
    logic       new_pix;
    logic       h_rise;
    logic       v_rise;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk (
        .clk     (clk),
        .reset_n (reset_n)
    );

    vid_controller dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .cmd         (cmd),
        .addr_data   (addr_data),
        .pixel_ready (pixel_ready),
        .overflow    (overflow),
        .underflow   (underflow),
        .hsync       (hsync),
        .hblank      (hblank),
        .vsync       (vsync),
        .vblank      (vblank),
        .rgb         (rgb)
    );

    assign status  = {hblank, vblank, hsync, vsync, overflow, underflow, pixel_ready};
    assign new_pix = (rgb != '0) && (rgb != rgb_prev);
    assign h_rise  = hsync && !hsync_prev;
    assign v_rise  = vsync && !vsync_prev;

    // Reference model updated on every clock edge
    always @(posedge clk) begin
        int nxt;
        nxt = new_pix ? chk_idx + 1 : chk_idx;
        chk_idx    <= nxt;
        exp_pix    <= (nxt < ref_q.size()) ? ref_q[nxt] : '0;
        rgb_prev   <= rgb;
        blank_prev <= hblank || vblank;
        hsync_prev <= hsync;
        vsync_prev <= vsync;
        cyc        <= cyc + 1;
        if (h_rise) begin
            last_hrise <= cyc;
            hrise_cnt  <= hrise_cnt + 1;
        end
        if (v_rise) begin
            last_vrise <= cyc;
            vrise_cnt  <= vrise_cnt + 1;
        end
    end

    task automatic report_mismatch(input int test, input string name,
                                   input logic [31:0] exp_val, input logic [31:0] act_val);
        $display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, exp_val, act_val);
        fail_cnt[test] = fail_cnt[test] + 1;
    endtask

    task automatic finish_test(input int test, input string name);
        $display("test %0d %s: %s (%0d errors)", test, name,
                 (fail_cnt[test] == 0) ? "ok" : "fail", fail_cnt[test]);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        #1;
        cmd       = `VID_CMD_IDLE;
        addr_data = '0;
    endtask

    task automatic write_reg(input logic [31:0] offset, input logic [31:0] data);
        @(posedge clk);
        #1;
        cmd       = `VID_CMD_WR_ADDR;
        addr_data = offset;
        @(posedge clk);
        #1;
        cmd       = `VID_CMD_WR_DATA;
        addr_data = data;
        bus_idle();
    endtask

    task automatic send_pixel(input vid_rgb_t pix);
        @(posedge clk);
        #1;
        cmd       = `VID_CMD_PIXEL;
        addr_data = {{(`VID_DATA_W - `VID_RGB_W){1'b0}}, pix};
        if (ref_q.size() < PIXELS) begin
            ref_q.push_back(pix);           // Dropped by the DUT when full
        end
    endtask

    function automatic logic [31:0] pack_timing(input int hi, input int lo);
        return {{(`VID_DATA_W - 2 * `VID_TIMING_W){1'b0}}, `VID_TIMING_W'(hi),
                `VID_TIMING_W'(lo)};
    endfunction

    function automatic vid_rgb_t next_pixel(input int idx);
        vid_rgb_t pix;
        pix = 24'($random(seed)) + 24'(idx + 1);
        if (pix == '0) begin
            pix = 24'(idx + 1);
        end
        return pix;
    endfunction

    a_reset_status: assert property (@(posedge clk) disable iff (!reset_n)
        reset_chk |-> (status == 7'b1100001))
        else report_mismatch(1, "{hblank,vblank,hsync,vsync,overflow,underflow,pixel_ready}",
                             32'(7'b1100001), 32'($sampled(status)));
    a_reset_rgb: assert property (@(posedge clk) disable iff (!reset_n)
        reset_chk |-> (rgb == '0))
        else report_mismatch(1, "rgb", 32'd0, {8'h00, $sampled(rgb)});
    a_full: assert property (@(posedge clk) disable iff (!reset_n)
        (ovf_stage != 2'd0) |-> !pixel_ready)
        else report_mismatch(2, "pixel_ready", 32'd0, 32'($sampled(pixel_ready)));
    a_ovf_clear: assert property (@(posedge clk) disable iff (!reset_n)
        (ovf_stage == 2'd1) |-> !overflow)
        else report_mismatch(2, "overflow", 32'd0, 32'($sampled(overflow)));
    a_ovf_set: assert property (@(posedge clk) disable iff (!reset_n)
        (ovf_stage == 2'd2) |-> overflow)
        else report_mismatch(2, "overflow", 32'd1, 32'($sampled(overflow)));
    a_line_period: assert property (@(posedge clk) disable iff (!reset_n)
        (h_rise && hrise_cnt > 0) |-> (cyc - last_hrise == LINE_CLKS))
        else report_mismatch(3, "hsync period", LINE_CLKS,
                             $sampled(cyc) - $sampled(last_hrise));
    a_frame_period: assert property (@(posedge clk) disable iff (!reset_n)
        (v_rise && vrise_cnt > 0) |-> (cyc - last_vrise == FRAME_CLKS))
        else report_mismatch(3, "vsync period", FRAME_CLKS,
                             $sampled(cyc) - $sampled(last_vrise));
    a_pixel_order: assert property (@(posedge clk) disable iff (!reset_n)
        new_pix |-> (rgb == exp_pix))
        else report_mismatch(4, "rgb", {8'h00, $sampled(exp_pix)}, {8'h00, $sampled(rgb)});
    a_blank_rgb: assert property (@(posedge clk) disable iff (!reset_n)
        blank_prev |-> (rgb == '0))
        else report_mismatch(5, "rgb", 32'd0, {8'h00, $sampled(rgb)});
    a_empty_rgb: assert property (@(posedge clk) disable iff (!reset_n)
        (chk_idx == PIXELS && !hblank && !vblank) |-> (rgb == '0))
        else report_mismatch(6, "rgb", 32'd0, {8'h00, $sampled(rgb)});
    a_underflow: assert property (@(posedge clk) disable iff (!reset_n)
        uf_chk |-> underflow)
        else report_mismatch(6, "underflow", 32'd1, 32'($sampled(underflow)));

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int n_failed;
        cmd       = `VID_CMD_IDLE;
        addr_data = '0;
        n_failed  = 0;

        @(posedge reset_n);
        idle_cycles(1);
        reset_chk = 1'b1;
        idle_cycles(4);
        reset_chk = 1'b0;
        finish_test(1, "reset");

        write_reg(`VID_REG_H1, pack_timing(4, HEND));     // hsize, hend
        write_reg(`VID_REG_H2, pack_timing(5, 6));        // hsync window
        write_reg(`VID_REG_V1, pack_timing(2, VEND));     // vsize, vend
        write_reg(`VID_REG_V2, pack_timing(3, 4));        // vsync window
        for (int i = 0; i < PIXELS; i++) begin
            send_pixel(next_pixel(i));
        end
        bus_idle();
        ovf_stage = 2'd1;
        idle_cycles(3);
        send_pixel(next_pixel(PIXELS));                   // One too many
        bus_idle();
        ovf_stage = 2'd2;
        idle_cycles(3);
        ovf_stage = 2'd0;
        finish_test(2, "overflow");

        write_reg(`VID_REG_CR, (32'd1 << `VID_CR_EN_BIT) | (32'(PCNT) << `VID_CR_PCNT_LSB));

        while (chk_idx < PIXELS) idle_cycles(1);
        finish_test(4, "pixel order");

        // Frame after the last pixel runs from an empty FIFO
        while (hblank || vblank) idle_cycles(1);
        while (!vblank) idle_cycles(1);
        uf_chk = 1'b1;
        idle_cycles(3);
        finish_test(6, "underflow");

        while (vrise_cnt < 3) idle_cycles(1);
        finish_test(3, "line and frame timing");

        idle_cycles(FRAME_CLKS);
        finish_test(5, "blanking");

        for (int t = 1; t <= NUM_TESTS; t++) begin
            if (fail_cnt[t] != 0) begin
                n_failed++;
            end
        end
        $display("summary: %0d tests passed, %0d tests failed", NUM_TESTS - n_failed, n_failed);
        if (n_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
vid_pkg.sv
vid_bus_decode.sv
vid_pixel_fifo.sv
vid_timing_gen.sv
vid_pixel_out.sv
vid_controller.sv
tb_clock_gen.sv
tb_vid_controller.sv

// File: run.sh
#!/usr/bin/env bash
# Build the video controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_vid_controller -o sim_vid

output=$(./obj_dir/sim_vid)
echo "$output"

if grep -q "TEST PASSED" <<< "$output"; then
    exit 0
fi
exit 1
